//--- rtl/gamePkg.sv
/*
 * Game package
 * Play-field geometry, sprite sizes, key scan codes and the types
 * shared by the enemy blocks
 */
package gamePkg;

    localparam int coordWidth = 9;
    localparam int addrWidth = 14;
    localparam int enemyCount = 4;

    typedef logic [coordWidth-1:0] coordT;
    // One extra bit so box edges near the right border do not wrap
    typedef logic [coordWidth:0] wideT;
    typedef logic [addrWidth-1:0] addrT;

    localparam int spriteW = 26;
    localparam int spriteH = 26;
    localparam int playerW = 18;
    localparam int playerH = 20;
    localparam int attackReach = 3;
    localparam int knockBack = 3;

    localparam int fieldXMin = 0;
    localparam int fieldXMax = 319;
    localparam int fieldYMin = 52;
    localparam int fieldYMax = 205;

    localparam logic [2:0] stunLast = 3'd6;

    // Keyboard scan codes
    localparam logic [7:0] keyW = 8'd26;
    localparam logic [7:0] keyA = 8'd4;
    localparam logic [7:0] keyS = 8'd22;
    localparam logic [7:0] keyD = 8'd7;
    localparam logic [7:0] keyG = 8'd10;

    // Start corners, indexed by enemy id
    localparam coordT startX [enemyCount] = '{9'd5, 9'd315, 9'd315, 9'd5};
    localparam coordT startY [enemyCount] = '{9'd65, 9'd65, 9'd180, 9'd180};

    typedef enum logic [1:0] {
        down  = 2'd0,
        left  = 2'd1,
        up    = 2'd2,
        right = 2'd3
    } dirT;

    typedef struct packed {
        coordT x;
        coordT y;
    } pointT;

    typedef struct packed {
        logic up;
        logic left;
        logic down;
        logic right;
        logic possess;
    } keysT;

    typedef struct packed {
        logic hit;
        addrT addr;
    } pixelT;

endpackage

//--- rtl/keyDecoder.sv
/*
 * Key decoder
 * Finds the movement keys in either keycode slot and keeps the
 * possession toggle driven by the G key
 */
`timescale 1ns/1ps

module keyDecoder (
    input  logic          Clk,
    input  logic          rstN,
    input  logic          frameTick,
    input  logic [15:0]   keycode,
    output gamePkg::keysT keys
);

    logic possessQ;
    logic gDown;

    // A key is down when it sits in either byte
    function automatic logic isDown(input logic [15:0] codes, input logic [7:0] scan);
        return (codes[7:0] == scan) || (codes[15:8] == scan);
    endfunction

    assign gDown = isDown(keycode, gamePkg::keyG);

    // Flips once per frame while G is held
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            possessQ <= 1'b0;
        end else if (frameTick && gDown) begin
            possessQ <= !possessQ;
        end
    end

    always_comb begin
        keys.up      = isDown(keycode, gamePkg::keyW);
        keys.left    = isDown(keycode, gamePkg::keyA);
        keys.down    = isDown(keycode, gamePkg::keyS);
        keys.right   = isDown(keycode, gamePkg::keyD);
        keys.possess = possessQ;
    end

endmodule

//--- rtl/walkAnimator.sv
/*
 * Walk animator
 * Two-bit walk-cycle counter that picks the enemy's pose
 */
`timescale 1ns/1ps

module walkAnimator (
    input  logic       Clk,
    input  logic       rstN,
    input  logic       frameTick,
    input  logic       moving,
    output logic [1:0] stepCount
);

    // A blocked or stunned enemy keeps its pose
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            stepCount <= 2'd0;
        end else if (frameTick && moving) begin
            stepCount <= stepCount + 2'd1;
        end
    end

    // Pose only ever changes on a frame boundary
    stepOnFrame: assert property (
        @(posedge Clk) disable iff (!rstN)
        !frameTick |=> $stable(stepCount)
    ) else $error("stepCount changed without frameTick");

endmodule

//--- rtl/enemyWalker.sv
/*
 * Enemy walker
 * Chases the player one pixel per frame, or follows the keys while
 * possessed; handles knock-back, stun, attack-ready and sprite lookup
 */
`timescale 1ns/1ps

module enemyWalker #(
    parameter int id = 0
) (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           frameTick,
    input  gamePkg::keysT  keys,
    input  gamePkg::pointT player,
    input  gamePkg::pointT pixel,
    input  logic           attacked,
    input  logic           attacked2,
    input  logic           alive,
    output gamePkg::pointT pos,
    output logic           attackReady,
    output gamePkg::pixelT sprite
);

    gamePkg::dirT   dir;
    gamePkg::dirT   dirNext;
    gamePkg::pointT posNext;
    gamePkg::coordT motionX;
    gamePkg::coordT motionY;
    gamePkg::coordT kbStep;
    gamePkg::coordT oneStep;
    gamePkg::coordT offX;
    gamePkg::coordT offY;
    gamePkg::wideT  enemyRight;
    gamePkg::wideT  enemyBottom;
    gamePkg::wideT  playerRight;
    gamePkg::wideT  playerBottom;
    gamePkg::wideT  reach;
    logic [2:0]     stunCnt;
    logic [2:0]     stunNext;
    logic [1:0]     stepCount;
    logic [1:0]     pose;
    logic           readyNext;
    logic           possessed;
    logic           struck;
    logic           moving;
    logic           goRight;
    logic           goLeft;
    logic           goDown;
    logic           goUp;
    logic           grownOverlap;
    logic           posInField;
    logic           inBox;

    assign struck    = attacked | attacked2;
    // Only enemy 0 can be taken over by the keyboard
    assign possessed = (id == 0) && keys.possess;
    assign kbStep    = gamePkg::coordT'(gamePkg::knockBack);
    assign oneStep   = gamePkg::coordT'(1);
    assign reach     = gamePkg::wideT'(gamePkg::attackReach);

    assign enemyRight   = gamePkg::wideT'(pos.x) + gamePkg::wideT'(gamePkg::spriteW);
    assign enemyBottom  = gamePkg::wideT'(pos.y) + gamePkg::wideT'(gamePkg::spriteH);
    assign playerRight  = gamePkg::wideT'(player.x) + gamePkg::wideT'(gamePkg::playerW);
    assign playerBottom = gamePkg::wideT'(player.y) + gamePkg::wideT'(gamePkg::playerH);

    // Wanted direction, before field limits
    assign goRight = possessed ? keys.right : (enemyRight < gamePkg::wideT'(player.x));
    assign goLeft  = possessed ? keys.left  : (gamePkg::wideT'(pos.x) > playerRight);
    assign goDown  = possessed ? keys.down  : (enemyBottom < gamePkg::wideT'(player.y));
    assign goUp    = possessed ? keys.up    : (gamePkg::wideT'(pos.y) > playerBottom);

    // Enemy box grown by the attack reach on every side
    assign grownOverlap = (enemyRight + reach >= gamePkg::wideT'(player.x)) &&
                          (gamePkg::wideT'(pos.x) <= playerRight + reach) &&
                          (enemyBottom + reach >= gamePkg::wideT'(player.y)) &&
                          (gamePkg::wideT'(pos.y) <= playerBottom + reach);

    // Hit loads 1 at once; the count then runs on frames up to stunLast
    always_comb begin
        stunNext = stunCnt;
        if (struck) begin
            stunNext = 3'd1;
        end else if (frameTick && stunCnt != 3'd0) begin
            stunNext = (stunCnt == gamePkg::stunLast) ? 3'd0 : stunCnt + 3'd1;
        end
    end

    always_comb begin
        motionX = '0;
        motionY = '0;
        dirNext = dir;
        if (stunCnt == 3'd1) begin
            // Knocked back against the facing
            case (dir)
                gamePkg::down:  motionY = -kbStep;
                gamePkg::left:  motionX = kbStep;
                gamePkg::up:    motionY = kbStep;
                default:        motionX = -kbStep;
            endcase
        end else if (stunCnt == 3'd0) begin
            if (goRight) begin
                dirNext = gamePkg::right;
                if (enemyRight < gamePkg::wideT'(gamePkg::fieldXMax)) begin
                    motionX = oneStep;
                end
            end else if (goLeft) begin
                dirNext = gamePkg::left;
                if (gamePkg::wideT'(pos.x) > gamePkg::wideT'(gamePkg::fieldXMin)) begin
                    motionX = -oneStep;
                end
            end else if (goDown) begin
                dirNext = gamePkg::down;
                if (enemyBottom < gamePkg::wideT'(gamePkg::fieldYMax)) begin
                    motionY = oneStep;
                end
            end else if (goUp) begin
                dirNext = gamePkg::up;
                if (gamePkg::wideT'(pos.y) > gamePkg::wideT'(gamePkg::fieldYMin)) begin
                    motionY = -oneStep;
                end
            end
        end
        posNext.x = pos.x + motionX;
        posNext.y = pos.y + motionY;
    end

    assign moving = (motionX != '0) || (motionY != '0);

    always_comb begin
        readyNext = 1'b0;
        if (frameTick && alive) begin
            if (possessed) begin
                readyNext = grownOverlap;
            end else begin
                // Stopped next to the player with nothing else going on
                readyNext = !moving && !struck && (stunCnt == 3'd0);
            end
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pos         <= '{x: gamePkg::startX[id], y: gamePkg::startY[id]};
            dir         <= gamePkg::down;
            stunCnt     <= 3'd0;
            attackReady <= 1'b0;
        end else begin
            stunCnt     <= stunNext;
            attackReady <= readyNext;
            if (frameTick && alive) begin
                pos <= posNext;
                dir <= dirNext;
            end
        end
    end

    walkAnimator anim0 (
        .Clk       (Clk),
        .rstN      (rstN),
        .frameTick (frameTick),
        .moving    (alive && moving),
        .stepCount (stepCount)
    );

    // Sprite pixel test and ROM address
    assign offX  = pixel.x - pos.x;
    assign offY  = pixel.y - pos.y;
    assign inBox = alive &&
                   (pixel.x >= pos.x) && (gamePkg::wideT'(pixel.x) < enemyRight) &&
                   (pixel.y >= pos.y) && (gamePkg::wideT'(pixel.y) < enemyBottom);

    always_comb begin
        if (struck || stunCnt != 3'd0) begin
            pose = 2'd3;
        end else if (!stepCount[0]) begin
            pose = 2'd0;
        end else begin
            pose = 2'd1 + {1'b0, stepCount[1]};
        end
    end

    // Frame index 4*dir + pose is just the two fields side by side
    always_comb begin
        sprite.hit  = inBox;
        sprite.addr = '0;
        if (inBox) begin
            sprite.addr = gamePkg::addrT'(offX) +
                          gamePkg::addrT'(offY) * gamePkg::addrT'(gamePkg::spriteW) +
                          gamePkg::addrT'(gamePkg::spriteW * gamePkg::spriteH) *
                          gamePkg::addrT'({dir, pose});
        end
    end

    assign posInField = (gamePkg::wideT'(pos.x) >= gamePkg::wideT'(gamePkg::fieldXMin)) &&
                        (gamePkg::wideT'(pos.x) <= gamePkg::wideT'(gamePkg::fieldXMax)) &&
                        (gamePkg::wideT'(pos.y) >= gamePkg::wideT'(gamePkg::fieldYMin)) &&
                        (gamePkg::wideT'(pos.y) <= gamePkg::wideT'(gamePkg::fieldYMax));

    // Ordinary steps never carry the enemy out of the field
    stayInField: assert property (
        @(posedge Clk) disable iff (!rstN)
        (posInField && stunCnt != 3'd1) |=> posInField
    ) else $error("enemy %0d left the field", id);

    // Frame strobes are spaced, so the pulse is one cycle wide
    readyPulse: assert property (
        @(posedge Clk) disable iff (!rstN)
        attackReady |=> !attackReady
    ) else $error("enemy %0d attackReady held two cycles", id);

endmodule

//--- rtl/enemyPixelMux.sv
/*
 * Enemy pixel mux
 * Picks the lowest-numbered enemy that covers the current pixel
 */
`timescale 1ns/1ps

module enemyPixelMux (
    input  gamePkg::pixelT sprites [gamePkg::enemyCount],
    output gamePkg::pixelT pixelOut
);

    // Walk from the top id down so the lowest hit is written last
    always_comb begin
        pixelOut = '0;
        for (int i = gamePkg::enemyCount - 1; i >= 0; i--) begin
            if (sprites[i].hit) begin
                pixelOut = sprites[i];
            end
        end
    end

    // Every walker reports a miss with a zero address
    always_comb begin
        for (int i = 0; i < gamePkg::enemyCount; i++) begin
            missIsZero: assert (sprites[i].hit || sprites[i].addr == '0)
                else $error("enemy %0d miss with address %h", i, sprites[i].addr);
        end
    end

endmodule

//--- rtl/enemySquad.sv
/*
 * Enemy squad
 * Top level with the key decoder, four enemy walkers and the pixel mux
 */
`timescale 1ns/1ps

module enemySquad (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           frameTick,
    input  logic [15:0]    keycode,
    input  gamePkg::pointT player,
    input  gamePkg::pointT pixel,
    input  logic [3:0]     attacked,
    input  logic [3:0]     attacked2,
    input  logic [3:0]     alive,
    output gamePkg::pointT enemyPos [gamePkg::enemyCount],
    output logic [3:0]     attackReady,
    output gamePkg::pixelT enemyPixel
);

    gamePkg::keysT  keys;
    gamePkg::pixelT sprites [gamePkg::enemyCount];

    keyDecoder keys0 (
        .Clk       (Clk),
        .rstN      (rstN),
        .frameTick (frameTick),
        .keycode   (keycode),
        .keys      (keys)
    );

    // Start corner and key control follow from the index
    for (genvar i = 0; i < gamePkg::enemyCount; i++) begin : walkers
        enemyWalker #(.id(i)) walker (
            .Clk         (Clk),
            .rstN        (rstN),
            .frameTick   (frameTick),
            .keys        (keys),
            .player      (player),
            .pixel       (pixel),
            .attacked    (attacked[i]),
            .attacked2   (attacked2[i]),
            .alive       (alive[i]),
            .pos         (enemyPos[i]),
            .attackReady (attackReady[i]),
            .sprite      (sprites[i])
        );
    end

    enemyPixelMux mux0 (
        .sprites  (sprites),
        .pixelOut (enemyPixel)
    );

endmodule

//--- test/enemySquadTb.sv
/*
 * Enemy squad testbench
 * Replays golden records of frames, keys and hits, then checks the
 * enemy positions, the attack-ready mask and the probed sprite pixel
 */
`timescale 1ns/1ps

module enemySquadTb;

    localparam int recordWords = 20;
    localparam int goldenDepth = 512;

    logic           Clk;
    logic           rstN;
    logic           frameTick;
    logic [15:0]    keycode;
    gamePkg::pointT player;
    gamePkg::pointT pixel;
    logic [3:0]     attacked;
    logic [3:0]     attacked2;
    logic [3:0]     alive;
    gamePkg::pointT enemyPos [gamePkg::enemyCount];
    logic [3:0]     attackReady;
    gamePkg::pixelT enemyPixel;

    // Word 0 is the record count, records follow
    logic [31:0] golden [goldenDepth];
    logic [3:0]  readySeen;
    int          recordCount;
    int          cycleLimit;
    int          cycleCount = 0;
    int          checkErrors;
    int          failedTests;

    enemySquad dut0 (
        .Clk         (Clk),
        .rstN        (rstN),
        .frameTick   (frameTick),
        .keycode     (keycode),
        .player      (player),
        .pixel       (pixel),
        .attacked    (attacked),
        .attacked2   (attacked2),
        .alive       (alive),
        .enemyPos    (enemyPos),
        .attackReady (attackReady),
        .enemyPixel  (enemyPixel)
    );

    always #5 Clk = !Clk;

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("FAIL %s expected %h got %h", name, expected, actual);
            checkErrors++;
        end
    endtask

    // Frame strobe, then seven quiet cycles
    task automatic runFrame();
        frameTick = 1'b1;
        @(posedge Clk);
        #1;
        frameTick = 1'b0;
        // attackReady pulses right after the frame edge
        readySeen = attackReady;
        repeat (7) begin
            @(posedge Clk);
            #1;
        end
    endtask

    task automatic playRecord(input int index);
        int base;
        int frames;
        int errorsBefore;
        base = 1 + index * recordWords;
        frames = int'(golden[base]);
        errorsBefore = checkErrors;
        player.x  = golden[base+1][8:0];
        player.y  = golden[base+2][8:0];
        keycode   = golden[base+3][15:0];
        alive     = golden[base+4][3:0];
        attacked  = golden[base+5][3:0];
        attacked2 = golden[base+6][3:0];
        pixel.x   = golden[base+7][8:0];
        pixel.y   = golden[base+8][8:0];
        // Mask as it stands when the record starts, kept if no frame runs
        readySeen = attackReady;
        // Hit strobes last one cycle
        @(posedge Clk);
        #1;
        attacked  = '0;
        attacked2 = '0;
        for (int f = 0; f < frames; f++) begin
            runFrame();
        end
        for (int e = 0; e < gamePkg::enemyCount; e++) begin
            checkField($sformatf("enemyPos[%0d].x", e), golden[base+9+2*e],
                       32'(enemyPos[e].x));
            checkField($sformatf("enemyPos[%0d].y", e), golden[base+10+2*e],
                       32'(enemyPos[e].y));
        end
        checkField("attackReady", golden[base+17], 32'(readySeen));
        checkField("enemyPixel.hit", golden[base+18], 32'(enemyPixel.hit));
        checkField("enemyPixel.addr", golden[base+19], 32'(enemyPixel.addr));
        if (checkErrors == errorsBefore) begin
            $display("test %0d ok after %0d frames", index, frames);
        end else begin
            $display("test %0d failed with %0d errors", index, checkErrors - errorsBefore);
            failedTests++;
        end
    endtask

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        frameTick = 1'b0;
        keycode = '0;
        player = '0;
        pixel = '0;
        attacked = '0;
        attacked2 = '0;
        alive = '1;
        readySeen = '0;
        checkErrors = 0;
        failedTests = 0;
        $readmemh("test/enemyGolden.hex", golden);
        recordCount = int'(golden[0]);
        cycleLimit = 200;
        for (int r = 0; r < recordCount; r++) begin
            cycleLimit += int'(golden[1 + r * recordWords]) * 8 + 1;
        end
        repeat (3) @(posedge Clk);
        #1;
        rstN = 1'b1;
        for (int r = 0; r < recordCount; r++) begin
            playRecord(r);
        end
        $display("%0d tests, %0d failed, %0d check errors", recordCount, failedTests,
                 checkErrors);
        if (checkErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Run stops here if the records take longer than their frames allow
    initial begin
        @(posedge Clk);
        while (cycleCount < cycleLimit) begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles", cycleCount);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- test/enemyGolden.hex
// First word is the record count; each record: frames playerX playerY keycode alive attacked
// attacked2 pixelX pixelY e0x e0y e1x e1y e2x e2y e3x e3y readyMask pixelHit pixelAddr
10
0 96 78 0 f 0 0 a 46 5 41 13b 41 13b b4 5 b4 0 1 87
a 96 78 0 f 0 0 136 46 f 41 131 41 131 b4 f b4 0 1 b17
2 190 78 0 f 0 0 132 b5 11 41 131 41 131 b4 11 b4 6 1 1fcb
1 96 78 0 f 1 8 14 46 e 41 130 41 130 b4 e b4 0 1 2824
5 96 78 0 f 0 0 14 46 e 41 12b 41 12b b4 e b4 0 1 22dc
1 96 78 0 f 0 0 f cd f 41 12a 41 12a b4 f b4 0 1 223a
2 2a 41 0 f 0 0 29 5a 10 41 128 41 128 b4 10 b3 1 1 279b
1 2a 41 a00 f 0 0 0 0 10 41 127 41 127 b4 10 b2 1 0 0
3 2a 41 7 f 0 0 13 41 13 41 124 41 124 b4 10 af 1 1 1fb0
f 2a 41 1a f 0 0 1e 3c 13 34 115 41 115 b4 10 a0 1 1 1b43
2 2a 41 1604 f 0 0 14 aa 11 34 113 41 113 b4 10 9e 1 1 1900
1 2a 41 a f 0 0 64 64 11 34 112 41 112 b4 10 9d 1 0 0
3 64 78 0 f 0 0 15 35 14 34 10f 41 10f b4 13 9d 0 1 1fcb
61 14 28 0 e 0 0 1e 46 14 34 ae 41 ae b4 13 3c 0 1 162f
0 14 28 0 f 0 0 1e 46 14 34 ae 41 ae b4 13 3c 0 1 218e
1 14 28 0 7 0 0 13 55 14 34 ad 41 ad b4 13 3c 1 0 0

//--- enemySquad.f
rtl/gamePkg.sv
rtl/keyDecoder.sv
rtl/walkAnimator.sv
rtl/enemyWalker.sv
rtl/enemyPixelMux.sv
rtl/enemySquad.sv
test/enemySquadTb.sv

//--- run.sh
#!/bin/sh
# Builds the enemy squad testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module enemySquadTb -f enemySquad.f -o enemySquadSim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/enemySquadSim 2>&1 | tee sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log && exit 0 || { echo "simulation ended early"; exit 1; }
